/* src/conv_pkg.sv */
// fixed data widths for the whole engine; KX*KY of any instance must not exceed MAX_TAPS
`default_nettype none

package conv_pkg;

    // largest kernel the packed window and weight arrays can carry (5x5)
    localparam int MAX_TAPS = 25;

    // unsigned feature-map pixel
    typedef logic        [7:0]  pixel_t;
    // signed kernel weight
    typedef logic signed [7:0]  weight_t;
    // 9-bit zero-extended pixel times 8-bit weight
    typedef logic signed [15:0] product_t;
    // room for the sum of 25 products
    typedef logic signed [20:0] acc_t;
    typedef logic signed [15:0] bias_t;
    // unsigned output pixel after ReLU and saturation
    typedef logic        [7:0]  opix_t;

    // tap index is row * KX + column, row 0 is the oldest line
    // taps at or above KX*KY are zero
    typedef struct packed {
        pixel_t [MAX_TAPS-1:0] tap;
    } window_t;

    // same tap indexing as window_t
    typedef struct packed {
        weight_t [MAX_TAPS-1:0] tap;
    } weights_t;

endpackage

`default_nettype wire

/* src/lut_multiplier.sv */
// multiply stays in fabric logic, so wide operands give long paths; product holds when disabled
`timescale 1ns/1ps
`default_nettype none

module lut_multiplier #(
    parameter int A_BW = 9,
    parameter int B_BW = 8,
    parameter int P_BW = 16
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   i_enable,
    input  logic signed [A_BW-1:0] i_a,
    input  logic signed [B_BW-1:0] i_b,
    output logic signed [P_BW-1:0] o_product
);

    // keep the multiply out of the DSP slices
    (* use_dsp = "no" *)
    logic signed [P_BW-1:0] product_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            product_q <= '0;
        end else if (i_enable) begin
            product_q <= P_BW'(i_a * i_b);
        end
    end

    assign o_product = product_q;

endmodule

`default_nettype wire

/* src/window_buffer.sv */
// needs 2 <= KX,KY, KX*KY <= 25 and KX <= IMG_W; a pixel in the i_frame_start cycle is dropped
`timescale 1ns/1ps
`default_nettype none

module window_buffer #(
    parameter int KX    = 5,
    parameter int KY    = 5,
    parameter int IMG_W = 16
) (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              i_frame_start,
    input  logic              i_pix_valid,
    input  conv_pkg::pixel_t  i_pix,
    output logic              o_win_valid,
    output conv_pkg::window_t o_win
);

    import conv_pkg::*;

    localparam int COL_W = $clog2(IMG_W);
    // row only needs to count up to KY-1, then it saturates
    localparam int ROW_W = $clog2(KY + 1);

    localparam logic [COL_W-1:0] COL_LAST  = COL_W'(IMG_W - 1);
    localparam logic [COL_W-1:0] COL_FIRST = COL_W'(KX - 1);
    localparam logic [ROW_W-1:0] ROW_FULL  = ROW_W'(KY - 1);

    logic [COL_W-1:0] col_q;
    logic [ROW_W-1:0] row_q;
    logic             accept;
    logic             position_done;

    // one memory per stored line, line 0 holds the previous row
    pixel_t line_mem [KY-1][IMG_W];

    // vertical slice at the current column, index KY-1 is the newest row
    pixel_t [KY-1:0] col_stack;

    // KX columns of the window, column KX-1 is the newest
    pixel_t [KX-1:0][KY-1:0] win_q;

    assign accept        = i_pix_valid && !i_frame_start;
    assign position_done = (row_q == ROW_FULL) && (col_q >= COL_FIRST);

    // raster position of the next pixel
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            col_q <= '0;
            row_q <= '0;
        end else if (i_frame_start) begin
            col_q <= '0;
            row_q <= '0;
        end else if (accept) begin
            if (col_q == COL_LAST) begin
                col_q <= '0;
                if (row_q != ROW_FULL) begin
                    row_q <= row_q + 1'b1;
                end
            end else begin
                col_q <= col_q + 1'b1;
            end
        end
    end

    always_comb begin
        col_stack[KY-1] = i_pix;
        for (int y = 0; y < KY - 1; y++) begin
            col_stack[y] = line_mem[KY-2-y][col_q];
        end
    end

    // each line moves one memory further back, read before write at the same column
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int k = 0; k < KY - 1; k++) begin
                line_mem[k][col_q] <= col_stack[KY-1-k];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            win_q <= {col_stack, win_q[KX-1:1]};
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_win_valid <= 1'b0;
        end else begin
            o_win_valid <= accept && position_done;
        end
    end

    // flatten to row * KX + column, unused taps stay zero
    always_comb begin
        o_win = '0;
        for (int y = 0; y < KY; y++) begin
            for (int x = 0; x < KX; x++) begin
                o_win.tap[y*KX + x] = win_q[x][y];
            end
        end
    end

endmodule

`default_nettype wire

/* src/cnn_kernel.sv */
// latency is fixed at 4 cycles and a new window may arrive every cycle; KX*KY must not exceed 25
`timescale 1ns/1ps
`default_nettype none

module cnn_kernel #(
    parameter int KX = 5,
    parameter int KY = 5
) (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               i_win_valid,
    input  conv_pkg::window_t  i_win,
    input  conv_pkg::weights_t i_weights,
    output logic               o_acc_valid,
    output conv_pkg::acc_t     o_acc
);

    import conv_pkg::*;

    localparam int TAPS    = KX * KY;
    localparam int LATENCY = 4;

    logic [LATENCY-1:0] valid_sr;

    pixel_t   pix_q [TAPS];
    weight_t  wgt_q [TAPS];
    product_t products [TAPS];

    acc_t acc_sum;
    acc_t acc_q;
    acc_t acc_out_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[LATENCY-2:0], i_win_valid};
        end
    end

    // stage 1
    always_ff @(posedge clk) begin
        if (i_win_valid) begin
            for (int t = 0; t < TAPS; t++) begin
                pix_q[t] <= i_win.tap[t];
                wgt_q[t] <= i_weights.tap[t];
            end
        end
    end

    // stage 2, pixel gets a zero sign bit so the multiply is signed
    for (genvar t = 0; t < TAPS; t++) begin : gen_mul
        lut_multiplier #(
            .A_BW ($bits(pixel_t) + 1),
            .B_BW ($bits(weight_t)),
            .P_BW ($bits(product_t))
        ) u_mul (
            .clk       (clk),
            .reset_n   (reset_n),
            .i_enable  (valid_sr[0]),
            .i_a       ($signed({1'b0, pix_q[t]})),
            .i_b       (wgt_q[t]),
            .o_product (products[t])
        );
    end

    always_comb begin
        acc_sum = '0;
        for (int t = 0; t < TAPS; t++) begin
            acc_sum = acc_sum + acc_t'(products[t]);
        end
    end

    // stage 3 sums, stage 4 lines the result up with the valid
    always_ff @(posedge clk) begin
        if (valid_sr[1]) begin
            acc_q <= acc_sum;
        end
        if (valid_sr[2]) begin
            acc_out_q <= acc_q;
        end
    end

    assign o_acc_valid = valid_sr[LATENCY-1];
    assign o_acc       = acc_out_q;

endmodule

`default_nettype wire

/* src/bias_relu.sv */
// no requantization shift: the biased sum is clamped straight into the 8-bit output range
`timescale 1ns/1ps
`default_nettype none

module bias_relu (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            i_acc_valid,
    input  conv_pkg::acc_t  i_acc,
    input  conv_pkg::bias_t i_bias,
    output logic            o_valid,
    output conv_pkg::opix_t o_pix
);

    import conv_pkg::*;

    // one extra bit so accumulator plus bias cannot wrap
    localparam int SUM_BW = $bits(acc_t) + 1;

    localparam logic signed [SUM_BW-1:0] SAT_MAX = SUM_BW'((1 << $bits(opix_t)) - 1);

    logic signed [SUM_BW-1:0] sum;
    opix_t                    clamped;

    assign sum = SUM_BW'(i_acc) + SUM_BW'(i_bias);

    always_comb begin
        if (sum[SUM_BW-1]) begin
            clamped = '0;
        end else if (sum > SAT_MAX) begin
            clamped = '1;
        end else begin
            clamped = opix_t'(sum);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_acc_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_acc_valid) begin
            o_pix <= clamped;
        end
    end

endmodule

`default_nettype wire

/* src/conv_top.sv */
// no back-pressure: o_pix must be taken on o_valid, 6 cycles after the pixel completing the window
`timescale 1ns/1ps
`default_nettype none

module conv_top #(
    parameter int KX    = 5,
    parameter int KY    = 5,
    parameter int IMG_W = 16
) (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               i_frame_start,
    input  logic               i_pix_valid,
    input  conv_pkg::pixel_t   i_pix,
    // weights and bias only change while the stream is idle
    input  conv_pkg::weights_t i_weights,
    input  conv_pkg::bias_t    i_bias,
    output logic               o_valid,
    output conv_pkg::opix_t    o_pix
);

    import conv_pkg::*;

    logic    win_valid;
    window_t win;
    logic    acc_valid;
    acc_t    acc;

    window_buffer #(
        .KX    (KX),
        .KY    (KY),
        .IMG_W (IMG_W)
    ) u_window_buffer (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_frame_start (i_frame_start),
        .i_pix_valid   (i_pix_valid),
        .i_pix         (i_pix),
        .o_win_valid   (win_valid),
        .o_win         (win)
    );

    cnn_kernel #(
        .KX (KX),
        .KY (KY)
    ) u_cnn_kernel (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_win_valid (win_valid),
        .i_win       (win),
        .i_weights   (i_weights),
        .o_acc_valid (acc_valid),
        .o_acc       (acc)
    );

    bias_relu u_bias_relu (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_acc_valid (acc_valid),
        .i_acc       (acc),
        .i_bias      (i_bias),
        .o_valid     (o_valid),
        .o_pix       (o_pix)
    );

endmodule

`default_nettype wire

/* test/conv_top_asserts.sv */
// bound into every conv_top; the 4-cycle check assumes the fixed cnn_kernel pipeline
`timescale 1ns/1ps
`default_nettype none

module conv_top_asserts (
    input logic            clk,
    input logic            reset_n,
    input logic            i_win_valid,
    input logic            i_acc_valid,
    input logic            i_out_valid,
    input conv_pkg::opix_t i_out_pix
);

    a_no_valid_in_reset: assert property (@(posedge clk) !reset_n |-> !i_out_valid)
        else $error("o_valid is high while reset_n is low");

    // kernel latency from window to accumulator
    a_kernel_latency: assert property (@(posedge clk) disable iff (!reset_n)
        i_acc_valid == $past(i_win_valid, 4))
        else $error("acc_valid is not win_valid delayed by 4 cycles");

    a_pix_known: assert property (@(posedge clk) disable iff (!reset_n)
        i_out_valid |-> !$isunknown(i_out_pix))
        else $error("o_pix has unknown bits while o_valid is high");

endmodule

bind conv_top conv_top_asserts u_conv_top_asserts (
    .clk         (clk),
    .reset_n     (reset_n),
    .i_win_valid (win_valid),
    .i_acc_valid (acc_valid),
    .i_out_valid (o_valid),
    .i_out_pix   (o_pix)
);

`default_nettype wire

/* test/conv_top_tb.sv */
// runs conv_top at KX=KY=3 and IMG_W=8 on 8-row frames; the latency check assumes 6 cycles
`timescale 1ns/1ps
`default_nettype none

module conv_top_tb;

    import conv_pkg::*;

    localparam int KX          = 3;
    localparam int KY          = 3;
    localparam int IMG_W       = 8;
    localparam int IMG_H       = 8;
    localparam int NPIX        = IMG_W * IMG_H;
    localparam int NOUT        = (IMG_W - KX + 1) * (IMG_H - KY + 1);
    localparam int LATENCY     = 6;
    localparam int DRAIN_LIMIT = 200;

    logic     clk;
    logic     reset_n;
    logic     i_frame_start;
    logic     i_pix_valid;
    pixel_t   i_pix;
    weights_t i_weights;
    bias_t    i_bias;
    logic     o_valid;
    opix_t    o_pix;

    int          errors = 0;
    int          cycle = 0;
    int unsigned lcg_state = 16;
    int          img [NPIX];
    int          wgt [KX*KY];
    int          bias_v;
    // expected pixels and the edge at which each completing pixel was sampled
    int          exp_q [$];
    int          due_q [$];
    int          got_q [$];
    int          ref_q [$];

    conv_top #(
        .KX    (KX),
        .KY    (KY),
        .IMG_W (IMG_W)
    ) conv_top_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_frame_start (i_frame_start),
        .i_pix_valid   (i_pix_valid),
        .i_pix         (i_pix),
        .i_weights     (i_weights),
        .i_bias        (i_bias),
        .o_valid       (o_valid),
        .o_pix         (o_pix)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic int lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[23:16]);
    endfunction

    // window sum over row * KX + column, row 0 oldest, then bias and clamp
    function automatic int model_pixel(int r, int c);
        int acc;
        acc = bias_v;
        for (int y = 0; y < KY; y++) begin
            for (int x = 0; x < KX; x++) begin
                acc += img[(r - KY + 1 + y) * IMG_W + c - KX + 1 + x] * wgt[y*KX + x];
            end
        end
        if (acc < 0) begin
            acc = 0;
        end else if (acc > 255) begin
            acc = 255;
        end
        return acc;
    endfunction

    task automatic check_value(string name, int expected, int actual);
        if (expected !== actual) begin
            errors++;
            $display("Error: %s expected %h actual %h at cycle %0d", name, expected, actual,
                     cycle);
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (reset_n && o_valid) begin
            got_q.push_back(int'(o_pix));
            if (exp_q.size() == 0) begin
                errors++;
                $display("extra output %h with no window pending at cycle %0d", o_pix, cycle);
            end else begin
                check_value("o_pix", exp_q.pop_front(), int'(o_pix));
                check_value("o_valid latency", LATENCY, cycle + 1 - due_q.pop_front());
            end
        end
    end

    task automatic apply_weights();
        weights_t w;
        w = '0;
        for (int t = 0; t < KX*KY; t++) begin
            w.tap[t] = weight_t'(wgt[t]);
        end
        i_weights = w;
        i_bias    = bias_t'(bias_v);
    endtask

    task automatic fill_random(bit bright);
        for (int p = 0; p < NPIX; p++) begin
            img[p] = bright ? 128 + lcg_next() % 128 : lcg_next();
        end
    endtask

    task automatic start_frame();
        i_frame_start = 1'b1;
        @(posedge clk);
        #2;
        i_frame_start = 1'b0;
        got_q.delete();
    endtask

    task automatic send_frame(int count, int max_gap);
        int r;
        int c;
        int gap;
        for (int p = 0; p < count; p++) begin
            gap = (max_gap > 0) ? lcg_next() % (max_gap + 1) : 0;
            i_pix_valid = 1'b0;
            repeat (gap) begin
                @(posedge clk);
                #2;
            end
            r = p / IMG_W;
            c = p % IMG_W;
            i_pix_valid = 1'b1;
            i_pix       = pixel_t'(img[p]);
            if (r >= KY - 1 && c >= KX - 1) begin
                exp_q.push_back(model_pixel(r, c));
                due_q.push_back(cycle + 1);
            end
            @(posedge clk);
            #2;
        end
        i_pix_valid = 1'b0;
    endtask

    task automatic drain(string what);
        int waited;
        waited = 0;
        while (exp_q.size() > 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() > 0) begin
            errors++;
            $display("%s: timed out with %0d outputs still missing", what, exp_q.size());
            exp_q.delete();
            due_q.delete();
        end
        // late extra outputs would show up in this window
        repeat (LATENCY + 2) @(posedge clk);
        #2;
    endtask

    task automatic test_idle();
        repeat (20) begin
            @(posedge clk);
            #2;
            check_value("o_valid", 0, int'(o_valid));
        end
    endtask

    task automatic test_identity();
        foreach (wgt[t]) wgt[t] = 0;
        wgt[(KY/2)*KX + KX/2] = 1;
        bias_v = 0;
        apply_weights();
        for (int p = 0; p < NPIX; p++) begin
            img[p] = (p * 4) % 256;
        end
        start_frame();
        send_frame(NPIX, 0);
        drain("identity kernel");
        check_value("output count", NOUT, got_q.size());
    endtask

    task automatic test_random();
        foreach (wgt[t]) wgt[t] = lcg_next() % 16 - 8;
        bias_v = lcg_next() * 4 - 512;
        apply_weights();
        fill_random(0);
        start_frame();
        send_frame(NPIX, 0);
        drain("random frame");
        check_value("output count", NOUT, got_q.size());
    endtask

    task automatic test_saturation();
        foreach (wgt[t]) wgt[t] = -(lcg_next() % 128) - 1;
        bias_v = 0;
        apply_weights();
        fill_random(0);
        start_frame();
        send_frame(NPIX, 0);
        drain("negative weights");
        check_value("output count", NOUT, got_q.size());
        foreach (got_q[i]) check_value("o_pix", 0, got_q[i]);
        foreach (wgt[t]) wgt[t] = 127;
        apply_weights();
        fill_random(1);
        start_frame();
        send_frame(NPIX, 0);
        drain("positive weights");
        check_value("output count", NOUT, got_q.size());
        foreach (got_q[i]) check_value("o_pix", 255, got_q[i]);
    endtask

    task automatic test_gaps();
        foreach (wgt[t]) wgt[t] = lcg_next() - 128;
        bias_v = lcg_next() * 64 - 8192;
        apply_weights();
        fill_random(0);
        start_frame();
        send_frame(NPIX, 0);
        drain("frame without gaps");
        ref_q = got_q;
        start_frame();
        send_frame(NPIX, 3);
        drain("frame with gaps");
        check_value("output count", ref_q.size(), got_q.size());
        for (int i = 0; i < ref_q.size() && i < got_q.size(); i++) begin
            check_value("o_pix", ref_q[i], got_q[i]);
        end
    endtask

    task automatic test_restart();
        foreach (wgt[t]) wgt[t] = lcg_next() % 8 - 4;
        bias_v = lcg_next();
        apply_weights();
        fill_random(0);
        start_frame();
        // stops inside row 3, which completes 6 + 2 windows
        send_frame(IMG_W * 3 + 4, 0);
        drain("partial frame");
        fill_random(0);
        start_frame();
        send_frame(NPIX, 0);
        drain("new frame after restart");
        check_value("output count", NOUT, got_q.size());
    endtask

    initial begin
        reset_n       = 1'b0;
        i_frame_start = 1'b0;
        i_pix_valid   = 1'b0;
        i_pix         = '0;
        i_weights     = '0;
        i_bias        = '0;
        repeat (4) @(posedge clk);
        #2;
        reset_n = 1'b1;
        test_idle();
        test_identity();
        test_random();
        test_saturation();
        test_gaps();
        test_restart();
        $display("tests finished with %0d errors", errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
src/conv_pkg.sv
src/lut_multiplier.sv
src/window_buffer.sv
src/cnn_kernel.sv
src/bias_relu.sv
src/conv_top.sv
test/conv_top_asserts.sv
test/conv_top_tb.sv

/* run.sh */
#!/bin/sh
# builds the conv_top testbench with Verilator, runs it and checks for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module conv_top_tb -f compile.f -o conv_top_sim

out=$(./obj_dir/conv_top_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q '^\*\* PASS \*\*$'; then
    exit 0
fi
exit 1
